// File: verilog/mipsPkg.sv
// shared widths, encodings and enumerations for the single-cycle MIPS core, referenced by scoped name
package mipsPkg;

  // ====================
  // widths and addresses
  // ====================
  localparam int dataWidth = 32;
  localparam int regAddrWidth = 5;
  // data memory holds 128 words
  localparam int memAddrWidth = 7;
  // j and jal carry a word index of this many bits
  localparam int jumpIdxWidth = 26;
  localparam logic [dataWidth-1:0] resetVector = 32'h0000_0000;
  // jal links into r31
  localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

  // ====================
  // major opcodes
  // ====================
  localparam logic [5:0] opRtype = 6'b000000;
  localparam logic [5:0] opJ = 6'b000010;
  localparam logic [5:0] opJal = 6'b000011;
  localparam logic [5:0] opBeq = 6'b000100;
  localparam logic [5:0] opAddi = 6'b001000;
  localparam logic [5:0] opLw = 6'b100011;
  localparam logic [5:0] opSw = 6'b101011;

  // ====================
  // r-type funct codes
  // ====================
  localparam logic [5:0] fnJr = 6'b001000;
  localparam logic [5:0] fnAdd = 6'b100000;
  localparam logic [5:0] fnSub = 6'b100010;
  localparam logic [5:0] fnAnd = 6'b100100;
  localparam logic [5:0] fnOr = 6'b100101;
  localparam logic [5:0] fnSlt = 6'b101010;

  // ====================
  // control enumerations
  // ====================
  // pass forwards operand b untouched
  typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluPass} aluOpT;

  // write-back value source
  typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSelT;

  // destination register source
  typedef enum logic [1:0] {dstRt, dstRd, dstLink} dstSelT;

endpackage

// File: verilog/instDecode.sv
// instruction decoder for the single-cycle core, turns one fetched word into all control signals
`timescale 1ns/10ps

module instDecode (
  input  logic [mipsPkg::dataWidth-1:0]    inst,
  output logic [mipsPkg::regAddrWidth-1:0] rsAddr,
  output logic [mipsPkg::regAddrWidth-1:0] rtAddr,
  output logic [mipsPkg::regAddrWidth-1:0] rdAddr,
  output logic [mipsPkg::dataWidth-1:0]    immExt,
  output logic [mipsPkg::jumpIdxWidth-1:0] jumpTarget,
  output mipsPkg::aluOpT                   aluOp,
  output logic                             aluSrcImm,
  output logic                             isBranch,
  output logic                             isJump,
  output logic                             isJumpReg,
  output logic                             regWrite,
  output mipsPkg::wbSelT                   wbSel,
  output mipsPkg::dstSelT                  dstSel,
  output logic                             memCen,
  output logic                             memWen
);

  logic [5:0] opcode;
  logic [5:0] funct;

  // ====================
  // field extraction
  // ====================
  assign opcode = inst[31:26];
  assign funct = inst[5:0];
  assign rsAddr = inst[25:21];
  assign rtAddr = inst[20:16];
  assign rdAddr = inst[15:11];
  // sign extension of the 16-bit immediate
  assign immExt = {{(mipsPkg::dataWidth-16){inst[15]}}, inst[15:0]};
  assign jumpTarget = inst[mipsPkg::jumpIdxWidth-1:0];

  // ====================
  // control and alu decode in one table
  // ====================
  always_comb begin
    // defaults describe a no-op
    aluOp = mipsPkg::aluPass;
    aluSrcImm = 1'b0;
    isBranch = 1'b0;
    isJump = 1'b0;
    isJumpReg = 1'b0;
    regWrite = 1'b0;
    wbSel = mipsPkg::wbAlu;
    dstSel = mipsPkg::dstRt;
    // both memory strobes idle high
    memCen = 1'b1;
    memWen = 1'b1;
    case (opcode)
      mipsPkg::opRtype: begin
        dstSel = mipsPkg::dstRd;
        case (funct)
          mipsPkg::fnAdd: begin aluOp = mipsPkg::aluAdd; regWrite = 1'b1; end
          mipsPkg::fnSub: begin aluOp = mipsPkg::aluSub; regWrite = 1'b1; end
          mipsPkg::fnAnd: begin aluOp = mipsPkg::aluAnd; regWrite = 1'b1; end
          mipsPkg::fnOr:  begin aluOp = mipsPkg::aluOr;  regWrite = 1'b1; end
          mipsPkg::fnSlt: begin aluOp = mipsPkg::aluSlt; regWrite = 1'b1; end
          // jr writes nothing
          mipsPkg::fnJr: isJumpReg = 1'b1;
          default: regWrite = 1'b0;
        endcase
      end
      mipsPkg::opAddi: begin
        aluOp = mipsPkg::aluAdd;
        aluSrcImm = 1'b1;
        regWrite = 1'b1;
      end
      mipsPkg::opLw: begin
        aluOp = mipsPkg::aluAdd;
        aluSrcImm = 1'b1;
        regWrite = 1'b1;
        wbSel = mipsPkg::wbMem;
        memCen = 1'b0;
      end
      mipsPkg::opSw: begin
        aluOp = mipsPkg::aluAdd;
        aluSrcImm = 1'b1;
        memCen = 1'b0;
        memWen = 1'b0;
      end
      // compare is done in execute so no alu op needed
      mipsPkg::opBeq: isBranch = 1'b1;
      mipsPkg::opJ: isJump = 1'b1;
      mipsPkg::opJal: begin
        isJump = 1'b1;
        regWrite = 1'b1;
        wbSel = mipsPkg::wbLink;
        dstSel = mipsPkg::dstLink;
      end
      default: regWrite = 1'b0;
    endcase
  end

endmodule

// File: verilog/regFile.sv
// general purpose register file with two combinational reads and one clocked write
`timescale 1ns/10ps

module regFile (
  input  logic                             clk,
  input  logic                             rst,
  input  logic [mipsPkg::regAddrWidth-1:0] rsAddr,
  input  logic [mipsPkg::regAddrWidth-1:0] rtAddr,
  output logic [mipsPkg::dataWidth-1:0]    rsData,
  output logic [mipsPkg::dataWidth-1:0]    rtData,
  input  logic                             regWrite,
  input  logic [mipsPkg::regAddrWidth-1:0] wAddr,
  input  logic [mipsPkg::dataWidth-1:0]    wData
);

  localparam int numRegs = 2 ** mipsPkg::regAddrWidth;

  // r0 has no storage
  logic [mipsPkg::dataWidth-1:0] regs [1:numRegs-1];

  // ====================
  // write port
  // ====================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (regWrite && (wAddr != '0)) begin
      // writes to r0 dropped here
      regs[wAddr] <= wData;
    end
  end

  // ====================
  // read ports
  // ====================
  // new value visible the cycle after the write
  assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
  assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

endmodule

// File: verilog/aluExecute.sv
// execute stage of the single-cycle core, operand select and the alu plus the beq compare
`timescale 1ns/10ps

module aluExecute (
  input  logic [mipsPkg::dataWidth-1:0] rsData,
  input  logic [mipsPkg::dataWidth-1:0] rtData,
  input  logic [mipsPkg::dataWidth-1:0] immExt,
  input  logic                          aluSrcImm,
  input  mipsPkg::aluOpT                aluOp,
  output logic [mipsPkg::dataWidth-1:0] aluResult,
  output logic                          branchTaken,
  input  logic                          isBranch
);

  logic [mipsPkg::dataWidth-1:0] opB;
  logic                          lessThan;

  // ====================
  // operand select
  // ====================
  // immediate for addi lw sw
  assign opB = aluSrcImm ? immExt : rtData;

  // signed compare for slt
  assign lessThan = $signed(rsData) < $signed(opB);

  // ====================
  // alu
  // ====================
  always_comb begin
    case (aluOp)
      mipsPkg::aluAdd: aluResult = rsData + opB;
      mipsPkg::aluSub: aluResult = rsData - opB;
      mipsPkg::aluAnd: aluResult = rsData & opB;
      mipsPkg::aluOr:  aluResult = rsData | opB;
      mipsPkg::aluSlt: aluResult = {{(mipsPkg::dataWidth-1){1'b0}}, lessThan};
      // pass and anything left over
      default:         aluResult = opB;
    endcase
  end

  // ====================
  // branch compare
  // ====================
  // beq compares the two register operands directly
  // independent of the alu op
  assign branchTaken = isBranch && (rsData == rtData);

endmodule

// File: verilog/pcUnit.sv
// program counter and next-fetch selection for sequential, branch, jump and jr flow
`timescale 1ns/10ps

module pcUnit (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             branchTaken,
  input  logic                             isJump,
  input  logic                             isJumpReg,
  input  logic [mipsPkg::dataWidth-1:0]    immExt,
  input  logic [mipsPkg::jumpIdxWidth-1:0] jumpTarget,
  input  logic [mipsPkg::dataWidth-1:0]    rsData,
  output logic [mipsPkg::dataWidth-1:0]    instAddr,
  output logic [mipsPkg::dataWidth-1:0]    pcPlus4
);

  logic [mipsPkg::dataWidth-1:0] pc;
  logic [mipsPkg::dataWidth-1:0] pcNext;
  logic [mipsPkg::dataWidth-1:0] branchAddr;
  logic [mipsPkg::dataWidth-1:0] jumpAddr;

  // ====================
  // candidate targets
  // ====================
  assign pcPlus4 = pc + 32'd4;
  // no delay slot so the offset is relative to pc+4
  assign branchAddr = pcPlus4 + {immExt[mipsPkg::dataWidth-3:0], 2'b00};
  // region bits from pc+4
  assign jumpAddr = {pcPlus4[31:28], jumpTarget, 2'b00};

  // priority jr then j/jal then beq
  always_comb begin
    if (isJumpReg) pcNext = rsData;
    else if (isJump) pcNext = jumpAddr;
    else if (branchTaken) pcNext = branchAddr;
    else pcNext = pcPlus4;
  end

  // ====================
  // pc register
  // ====================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) pc <= mipsPkg::resetVector;
    else pc <= pcNext;
  end

  assign instAddr = pc;

endmodule

// File: verilog/writeBack.sv
// write-back stage, picks the result and destination register for the register file write
`timescale 1ns/10ps

module writeBack (
  input  logic [mipsPkg::dataWidth-1:0]    aluResult,
  input  logic [mipsPkg::dataWidth-1:0]    memRdData,
  input  logic [mipsPkg::dataWidth-1:0]    pcPlus4,
  input  mipsPkg::wbSelT                   wbSel,
  input  logic [mipsPkg::regAddrWidth-1:0] rtAddr,
  input  logic [mipsPkg::regAddrWidth-1:0] rdAddr,
  input  mipsPkg::dstSelT                  dstSel,
  input  logic                             regWrite,
  output logic [mipsPkg::dataWidth-1:0]    wData,
  output logic [mipsPkg::regAddrWidth-1:0] wAddr,
  output logic                             we
);

  // result source
  always_comb begin
    case (wbSel)
      mipsPkg::wbMem:  wData = memRdData;
      // jal link value
      mipsPkg::wbLink: wData = pcPlus4;
      default:         wData = aluResult;
    endcase
  end

  // destination index
  always_comb begin
    case (dstSel)
      mipsPkg::dstRd:   wAddr = rdAddr;
      mipsPkg::dstLink: wAddr = mipsPkg::linkReg;
      default:          wAddr = rtAddr;
    endcase
  end

  assign we = regWrite;

endmodule

// File: verilog/mipsCore.sv
// top of the single-cycle MIPS core, connects fetch, decode, execute, write-back and both memory ports
`timescale 1ns/10ps

module mipsCore (
  input  logic                             clk,
  input  logic                             rst,
  // instruction port
  output logic [mipsPkg::dataWidth-1:0]    instAddr,
  input  logic [mipsPkg::dataWidth-1:0]    inst,
  // data port with active-low strobes
  output logic                             memCen,
  output logic                             memWen,
  output logic [mipsPkg::memAddrWidth-1:0] memAddr,
  output logic [mipsPkg::dataWidth-1:0]    memWrData,
  input  logic [mipsPkg::dataWidth-1:0]    memRdData,
  // register write test port
  output logic                             rfWe,
  output logic [mipsPkg::regAddrWidth-1:0] rfWaddr,
  output logic [mipsPkg::dataWidth-1:0]    rfWriteData
);

  logic [mipsPkg::regAddrWidth-1:0] rsAddr, rtAddr, rdAddr;
  logic [mipsPkg::dataWidth-1:0]    immExt, rsData, rtData, aluResult, pcPlus4;
  logic [mipsPkg::jumpIdxWidth-1:0] jumpTarget;
  mipsPkg::aluOpT                   aluOp;
  mipsPkg::wbSelT                   wbSel;
  mipsPkg::dstSelT                  dstSel;
  logic                             aluSrcImm, isBranch, isJump, isJumpReg;
  logic                             regWrite, branchTaken;

  // ====================
  // fetch and decode
  // ====================
  pcUnit pcUnit_i (
    .clk(clk), .rst(rst), .branchTaken(branchTaken), .isJump(isJump),
    .isJumpReg(isJumpReg), .immExt(immExt), .jumpTarget(jumpTarget),
    .rsData(rsData), .instAddr(instAddr), .pcPlus4(pcPlus4)
  );

  instDecode instDecode_i (
    .inst(inst), .rsAddr(rsAddr), .rtAddr(rtAddr), .rdAddr(rdAddr),
    .immExt(immExt), .jumpTarget(jumpTarget), .aluOp(aluOp),
    .aluSrcImm(aluSrcImm), .isBranch(isBranch), .isJump(isJump),
    .isJumpReg(isJumpReg), .regWrite(regWrite), .wbSel(wbSel),
    .dstSel(dstSel), .memCen(memCen), .memWen(memWen)
  );

  // ====================
  // registers and execute
  // ====================
  // write side fed back from write-back
  regFile regFile_i (
    .clk(clk), .rst(rst), .rsAddr(rsAddr), .rtAddr(rtAddr),
    .rsData(rsData), .rtData(rtData), .regWrite(rfWe),
    .wAddr(rfWaddr), .wData(rfWriteData)
  );

  aluExecute aluExecute_i (
    .rsData(rsData), .rtData(rtData), .immExt(immExt),
    .aluSrcImm(aluSrcImm), .aluOp(aluOp), .aluResult(aluResult),
    .branchTaken(branchTaken), .isBranch(isBranch)
  );

  // byte address to word index
  assign memAddr = aluResult[mipsPkg::memAddrWidth+1:2];
  // store data comes from rt
  assign memWrData = rtData;

  // ====================
  // write-back
  // ====================
  writeBack writeBack_i (
    .aluResult(aluResult), .memRdData(memRdData), .pcPlus4(pcPlus4),
    .wbSel(wbSel), .rtAddr(rtAddr), .rdAddr(rdAddr), .dstSel(dstSel),
    .regWrite(regWrite), .wData(rfWriteData), .wAddr(rfWaddr), .we(rfWe)
  );

endmodule

// File: bench/mipsCore_asserts.sv
// concurrent protocol assertions for the MIPS core, attached to every mipsCore instance with bind
`timescale 1ns/10ps

module mipsCore_asserts (
  input logic                          clk,
  input logic                          rst,
  input logic [mipsPkg::dataWidth-1:0] instAddr,
  input logic                          memCen,
  input logic                          memWen
);

  // fetch stays on word boundaries
  instAligned: assert property (@(posedge clk) disable iff (!rst) instAddr[1:0] == 2'b00)
    else $error("instruction address 0x%08h is not word aligned", instAddr);

  // write strobe only together with chip enable
  wenNeedsCen: assert property (@(posedge clk) !memWen |-> !memCen)
    else $error("memWen is low while memCen is high");

  // first cycle out of reset fetches the reset vector
  firstFetchAtReset: assert property (@(posedge clk) $rose(rst) |->
                                      instAddr == mipsPkg::resetVector)
    else $error("first fetch after reset at 0x%08h instead of the reset vector", instAddr);

  // no store while in reset
  noStoreInReset: assert property (@(posedge clk) !rst |-> memWen)
    else $error("memory write strobe active during reset");

endmodule

bind mipsCore mipsCore_asserts mipsCore_asserts_i (
  .clk(clk), .rst(rst), .instAddr(instAddr), .memCen(memCen), .memWen(memWen)
);

// File: bench/mipsCoreChecker.sv
// checker for the MIPS core testbench, compares core ports with the expected row and prints results
`timescale 1ns/10ps

module mipsCoreChecker #(
  parameter int tableSize = 32,
  parameter int haltRow = 26,
  parameter int expectedRuns = 22
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        finished,
  input  logic [31:0] instAddr,
  input  logic        rfWe,
  input  logic [4:0]  rfWaddr,
  input  logic [31:0] rfWriteData,
  input  logic        memCen,
  input  logic        memWen,
  input  logic [6:0]  memAddr,
  input  logic [31:0] memWrData,
  // expected values of the row selected by instAddr
  input  logic        expRun,
  input  logic        expWe,
  input  logic [4:0]  expWaddr,
  input  logic [31:0] expWdata,
  input  logic        expMemWe,
  input  logic        expMemRd,
  input  logic [6:0]  expMemAddr,
  input  logic [31:0] expMemData,
  output int          errCount,
  output logic        reportDone
);

  int runCount;
  int passCount;
  int rowErrs;
  int resetErrs;

  initial begin
    errCount = 0;
    runCount = 0;
    passCount = 0;
    rowErrs = 0;
    resetErrs = 0;
    reportDone = 1'b0;
  end

  // one value against its expectation
  task automatic compareHex(input string name, input logic [31:0] got,
                            input logic [31:0] exp, input string where);
    if (got !== exp) begin
      $display("FAIL %s %s: got 0x%08h, expected 0x%08h", where, name, got, exp);
      rowErrs++;
    end
  endtask

  // ====================
  // per-row compare
  // ====================
  task automatic checkRow();
    string where;
    where = $sformatf("row %0d", instAddr[31:2]);
    rowErrs = 0;
    if (instAddr[1:0] != 2'b00 || instAddr >= 32'(tableSize * 4)) begin
      $display("instruction address 0x%08h lies outside the program", instAddr);
      rowErrs++;
    end else if (instAddr != 32'(haltRow * 4)) begin
      runCount++;
      if (!expRun) begin
        $display("%s ran although the program should have skipped it", where);
        rowErrs++;
      end
      compareHex("rfWe", 32'(rfWe), 32'(expWe), where);
      // index and data only matter with a write
      if (expWe) begin
        compareHex("rfWaddr", 32'(rfWaddr), 32'(expWaddr), where);
        compareHex("rfWriteData", rfWriteData, expWdata, where);
      end
      compareHex("memWen", 32'(memWen), 32'(!expMemWe), where);
      // chip enable low only for lw and sw
      compareHex("memCen", 32'(memCen), 32'(!(expMemWe || expMemRd)), where);
      if (expMemWe) begin
        compareHex("memAddr", 32'(memAddr), 32'(expMemAddr), where);
        compareHex("memWrData", memWrData, expMemData, where);
      end
      if (rowErrs == 0) passCount++;
      $display("%s: %s", where, (rowErrs == 0) ? "pass" : "fail");
    end
    errCount += rowErrs;
  endtask

  // mid-cycle sampling, all core outputs settled
  always @(negedge clk) begin
    if (!rst) begin
      rowErrs = 0;
      compareHex("instAddr", instAddr, mipsPkg::resetVector, "reset");
      compareHex("rfWe", 32'(rfWe), 32'd0, "reset");
      compareHex("memWen", 32'(memWen), 32'd1, "reset");
      compareHex("memCen", 32'(memCen), 32'd1, "reset");
      resetErrs += rowErrs;
      errCount += rowErrs;
    end else if (!finished) begin
      checkRow();
    end
  end

  always @(posedge rst) begin
    $display("reset: %s", (resetErrs == 0) ? "pass" : "fail");
  end

  // ====================
  // summary
  // ====================
  always @(posedge finished) begin
    if (runCount != expectedRuns) begin
      $display("%0d rows executed where the program flow gives %0d", runCount, expectedRuns);
      errCount++;
    end
    $display("rows run: %0d, rows passed: %0d, errors: %0d", runCount, passCount, errCount);
    reportDone = 1'b1;
  end

endmodule

// File: bench/mipsCoreTb.sv
// testbench top for the single-cycle MIPS core, runs a program table with ROM and data memory models
`timescale 1ns/10ps

module mipsCoreTb;

  localparam int clkPeriod = 10;
  localparam int resetCycles = 2;
  // table slots match the 5-bit row index
  localparam int tableSize = 32;
  localparam int rowCount = 27;
  // last row jumps to itself and ends the run
  localparam int haltRow = 26;
  localparam int expectedRuns = 22;
  localparam int memWords = 2 ** mipsPkg::memAddrWidth;
  localparam int timeoutCycles = rowCount * 4 + resetCycles;
  localparam logic [31:0] haltAddr = haltRow * 4;

  logic        clk;
  logic        rst;
  logic [31:0] instAddr;
  logic [31:0] inst;
  logic        memCen;
  logic        memWen;
  logic [6:0]  memAddr;
  logic [31:0] memWrData;
  logic [31:0] memRdData;
  logic        rfWe;
  logic [4:0]  rfWaddr;
  logic [31:0] rfWriteData;
  logic        finished;
  logic        reportDone;
  int          errCount;

  // ====================
  // program table
  // ====================
  logic [31:0] tblInst [tableSize];
  logic        tblRun [tableSize];
  logic        tblWe [tableSize];
  logic [4:0]  tblWaddr [tableSize];
  logic [31:0] tblWdata [tableSize];
  logic        tblMemWe [tableSize];
  logic        tblMemRd [tableSize];
  logic [6:0]  tblMemAddr [tableSize];
  logic [31:0] tblMemData [tableSize];

  logic [31:0] rom [tableSize];
  logic [31:0] dataMem [memWords];
  logic [4:0]  rowIdx;

  // instruction assemblers
  function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                       input logic [4:0] rd, input logic [5:0] funct);
    return {mipsPkg::opRtype, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encJ(input logic [5:0] op, input logic [25:0] idx);
    return {op, idx};
  endfunction

  task automatic addRow(input int idx, input logic [31:0] word, input logic we,
                        input logic [4:0] waddr, input logic [31:0] wdata,
                        input logic memWe, input logic [6:0] maddr, input logic [31:0] mdata);
    tblInst[idx] = word;
    tblRun[idx] = 1'b1;
    tblWe[idx] = we;
    tblWaddr[idx] = waddr;
    tblWdata[idx] = wdata;
    tblMemWe[idx] = memWe;
    tblMemRd[idx] = 1'b0;
    tblMemAddr[idx] = maddr;
    tblMemData[idx] = mdata;
  endtask

  // row the program flow must never reach
  task automatic addSkippedRow(input int idx, input logic [31:0] word);
    addRow(idx, word, 1'b0, 5'd0, 32'd0, 1'b0, 7'd0, 32'd0);
    tblRun[idx] = 1'b0;
  endtask

  task automatic loadTable();
    for (int i = 0; i < tableSize; i++) begin
      addSkippedRow(i, 32'h0000_0000);
    end
    // all-zero word decodes as a no-op
    addRow(0, 32'h0000_0000, 1'b0, 5'd0, 32'd0, 1'b0, 7'd0, 32'd0);
    addRow(1, encI(mipsPkg::opAddi, 5'd0, 5'd1, 16'd5), 1'b1, 5'd1, 32'd5, 1'b0, 7'd0, 32'd0);
    addRow(2, encI(mipsPkg::opAddi, 5'd0, 5'd2, 16'hFFFD), 1'b1, 5'd2, 32'hFFFF_FFFD,
           1'b0, 7'd0, 32'd0);
    addRow(3, encR(5'd1, 5'd2, 5'd3, mipsPkg::fnAdd), 1'b1, 5'd3, 32'd2, 1'b0, 7'd0, 32'd0);
    addRow(4, encR(5'd1, 5'd2, 5'd4, mipsPkg::fnSub), 1'b1, 5'd4, 32'd8, 1'b0, 7'd0, 32'd0);
    addRow(5, encR(5'd1, 5'd2, 5'd5, mipsPkg::fnAnd), 1'b1, 5'd5, 32'd5, 1'b0, 7'd0, 32'd0);
    addRow(6, encR(5'd1, 5'd2, 5'd6, mipsPkg::fnOr), 1'b1, 5'd6, 32'hFFFF_FFFD,
           1'b0, 7'd0, 32'd0);
    // -3 < 5 signed, then 5 < -3
    addRow(7, encR(5'd2, 5'd1, 5'd7, mipsPkg::fnSlt), 1'b1, 5'd7, 32'd1, 1'b0, 7'd0, 32'd0);
    addRow(8, encR(5'd1, 5'd2, 5'd8, mipsPkg::fnSlt), 1'b1, 5'd8, 32'd0, 1'b0, 7'd0, 32'd0);
    // r0 write shows on the test port but must not stick
    addRow(9, encI(mipsPkg::opAddi, 5'd1, 5'd0, 16'd7), 1'b1, 5'd0, 32'd12, 1'b0, 7'd0, 32'd0);
    addRow(10, encR(5'd0, 5'd1, 5'd9, mipsPkg::fnAdd), 1'b1, 5'd9, 32'd5, 1'b0, 7'd0, 32'd0);
    // store r4 at byte 16, word 4, then load it back
    addRow(11, encI(mipsPkg::opSw, 5'd0, 5'd4, 16'd16), 1'b0, 5'd0, 32'd0, 1'b1, 7'd4, 32'd8);
    addRow(12, encI(mipsPkg::opLw, 5'd0, 5'd10, 16'd16), 1'b1, 5'd10, 32'd8,
           1'b0, 7'd0, 32'd0);
    // lw rows expect the read strobe
    tblMemRd[12] = 1'b1;
    // taken beq skips row 14
    addRow(13, encI(mipsPkg::opBeq, 5'd1, 5'd9, 16'd1), 1'b0, 5'd0, 32'd0, 1'b0, 7'd0, 32'd0);
    addSkippedRow(14, encI(mipsPkg::opAddi, 5'd0, 5'd11, 16'd99));
    addRow(15, encI(mipsPkg::opBeq, 5'd1, 5'd2, 16'd1), 1'b0, 5'd0, 32'd0, 1'b0, 7'd0, 32'd0);
    addRow(16, encI(mipsPkg::opAddi, 5'd0, 5'd12, 16'h0077), 1'b1, 5'd12, 32'h77,
           1'b0, 7'd0, 32'd0);
    // jal at byte 68 links 72
    addRow(17, encJ(mipsPkg::opJal, 26'd21), 1'b1, 5'd31, 32'h48, 1'b0, 7'd0, 32'd0);
    addRow(18, encJ(mipsPkg::opJ, 26'd24), 1'b0, 5'd0, 32'd0, 1'b0, 7'd0, 32'd0);
    addRow(21, encI(mipsPkg::opAddi, 5'd0, 5'd13, 16'h0055), 1'b1, 5'd13, 32'h55,
           1'b0, 7'd0, 32'd0);
    addRow(22, encR(5'd31, 5'd0, 5'd0, mipsPkg::fnJr), 1'b0, 5'd0, 32'd0, 1'b0, 7'd0, 32'd0);
    addSkippedRow(23, encI(mipsPkg::opAddi, 5'd0, 5'd11, 16'd66));
    // opcode 6'h3f is not implemented
    addRow(24, 32'hFC22_0001, 1'b0, 5'd0, 32'd0, 1'b0, 7'd0, 32'd0);
    // preloaded word 5
    addRow(25, encI(mipsPkg::opLw, 5'd0, 5'd14, 16'd20), 1'b1, 5'd14, 32'hD000_5005,
           1'b0, 7'd0, 32'd0);
    tblMemRd[25] = 1'b1;
    addRow(26, encJ(mipsPkg::opJ, 26'd26), 1'b0, 5'd0, 32'd0, 1'b0, 7'd0, 32'd0);
  endtask

  // ====================
  // clock, memories, DUT
  // ====================
  initial clk = 1'b0;
  always #(clkPeriod / 2) clk = ~clk;

  assign rowIdx = instAddr[6:2];
  assign inst = rom[rowIdx];
  // read data only while enabled for a read
  assign memRdData = (!memCen && memWen) ? dataMem[memAddr] : 32'd0;

  always @(posedge clk) begin
    if (!memCen && !memWen) dataMem[memAddr] <= memWrData;
  end

  mipsCore mipsCore_i (
    .clk(clk), .rst(rst), .instAddr(instAddr), .inst(inst), .memCen(memCen),
    .memWen(memWen), .memAddr(memAddr), .memWrData(memWrData), .memRdData(memRdData),
    .rfWe(rfWe), .rfWaddr(rfWaddr), .rfWriteData(rfWriteData)
  );

  mipsCoreChecker #(
    .tableSize(tableSize), .haltRow(haltRow), .expectedRuns(expectedRuns)
  ) mipsCoreChecker_i (
    .clk(clk), .rst(rst), .finished(finished), .instAddr(instAddr), .rfWe(rfWe),
    .rfWaddr(rfWaddr), .rfWriteData(rfWriteData), .memCen(memCen), .memWen(memWen),
    .memAddr(memAddr), .memWrData(memWrData), .expRun(tblRun[rowIdx]),
    .expWe(tblWe[rowIdx]), .expWaddr(tblWaddr[rowIdx]), .expWdata(tblWdata[rowIdx]),
    .expMemWe(tblMemWe[rowIdx]), .expMemRd(tblMemRd[rowIdx]),
    .expMemAddr(tblMemAddr[rowIdx]), .expMemData(tblMemData[rowIdx]),
    .errCount(errCount), .reportDone(reportDone)
  );

  // ====================
  // stimulus and end of run
  // ====================
  initial begin
    rst <= 1'b0;
    finished <= 1'b0;
    loadTable();
    for (int i = 0; i < tableSize; i++) begin
      rom[i] = tblInst[i];
    end
    // fill word depends on the full word index
    for (int i = 0; i < memWords; i++) begin
      dataMem[i] <= 32'hD000_0000 | (i << 12) | i;
    end
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b1;
    // wait for the program to reach its halt row
    @(negedge clk);
    while (instAddr != haltAddr) @(negedge clk);
    @(posedge clk);
    finished <= 1'b1;
    wait (reportDone);
    if (errCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(timeoutCycles * clkPeriod);
    $display("the program did not reach its halt row within %0d cycles", timeoutCycles);
    $display("Test failed");
    $finish;
  end

endmodule

// File: verilog.f
verilog/mipsPkg.sv
verilog/instDecode.sv
verilog/regFile.sv
verilog/aluExecute.sv
verilog/pcUnit.sv
verilog/writeBack.sv
verilog/mipsCore.sv
bench/mipsCore_asserts.sv
bench/mipsCoreChecker.sv
bench/mipsCoreTb.sv

// File: Makefile
# Verilator build for the single-cycle MIPS core and its testbench

VERILATOR  ?= verilator
TOP        ?= mipsCoreTb
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Test passed
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only when the log holds the pass message
sim: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
